//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
TOP       := tb_soc
FILELIST  := soc.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/gpio_wb.sv
`timescale 1ns/1ns

module gpio_wb
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  wb_m2s_t     wb_i,
    output wb_s2m_t     wb_o,
    input  logic [31:0] gpio_i,
    output logic [31:0] gpio_o,
    output logic [31:0] gpio_oe_o
);

    logic [31:0] in_meta;
    logic [31:0] in_sync;
    logic [31:0] dat_q;
    logic        ack_q;
    logic        access;
    logic [9:0]  offset;

    // Word offset within the block
    assign offset = wb_i.adr[11:2];
    assign access = wb_i.cyc && wb_i.stb && !ack_q;

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            gpio_o    <= 32'h0;
            gpio_oe_o <= 32'h0;
            ack_q     <= 1'b0;
        end
        else
        begin
            ack_q <= access;
            if (access && wb_i.we)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (wb_i.sel[i] && offset == 10'd0) gpio_o[8*i +: 8] <= wb_i.dat[8*i +: 8];
                    if (wb_i.sel[i] && offset == 10'd1) gpio_oe_o[8*i +: 8] <= wb_i.dat[8*i +: 8];
                end
            end
        end
    end

    // Two-flop input synchronizer, then read mux
    always_ff @(posedge clk)
    begin
        in_meta <= gpio_i;
        in_sync <= in_meta;
        if (access)
        begin
            case (offset)
                10'd0:   dat_q <= gpio_o;
                10'd1:   dat_q <= gpio_oe_o;
                10'd2:   dat_q <= in_sync;
                default: dat_q <= 32'h0;
            endcase
        end
    end

    assign wb_o = '{dat: dat_q, ack: ack_q, err: 1'b0};

endmodule : gpio_wb

//--- hw/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// ==============================
// Memory sizes
// ==============================

// Depth in 32-bit words
`define SOC_DMEM_DEPTH 128
`define SOC_IMEM_DEPTH 128

// ==============================
// Address map
// ==============================

// Compared against address bits 31:28
`define SOC_DMEM_BASE 4'h0
`define SOC_IMEM_BASE 4'h1
`define SOC_GPIO_BASE 4'h2

`endif

//--- hw/soc_pkg.sv
package soc_pkg;

    // ==============================
    // Processor port
    // ==============================

    // RV32 load/store size, encoded as funct3
    typedef enum logic [2:0] {
        op_byte   = 3'b000,
        op_half   = 3'b001,
        op_word   = 3'b010,
        op_byte_u = 3'b100,
        op_half_u = 3'b101
    } mem_op_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        read;
        logic        write;
        mem_op_e     op;
    } mem_req_t;

    // ==============================
    // Wishbone
    // ==============================

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_m2s_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
        logic        err;
    } wb_s2m_t;

    // Address decode result
    typedef enum logic [1:0] {
        reg_dmem = 2'd0,
        reg_imem = 2'd1,
        reg_gpio = 2'd2,
        reg_none = 2'd3
    } region_e;

endpackage : soc_pkg

//--- hw/soc_top.sv
`timescale 1ns/1ns
`include "soc_cfg.svh"

module soc_top
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  mem_req_t    req_i,
    output logic [31:0] rdata_o,
    output logic        stall_o,
    output logic        err_o,
    input  logic [31:0] gpio_i,
    output logic [31:0] gpio_o,
    output logic [31:0] gpio_oe_o
);

    wb_m2s_t cpu_m2s;
    wb_s2m_t cpu_s2m;
    wb_m2s_t dmem_m2s;
    wb_s2m_t dmem_s2m;
    wb_m2s_t imem_m2s;
    wb_s2m_t imem_s2m;
    wb_m2s_t gpio_m2s;
    wb_s2m_t gpio_s2m;

    // ==============================
    // Master side
    // ==============================

    wb_master_bridge u_bridge (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .rdata_o  (rdata_o),
        .stall_o  (stall_o),
        .err_o    (err_o),
        .wb_o     (cpu_m2s),
        .wb_i     (cpu_s2m)
    );

    wb_intercon u_intercon (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .m_i      (cpu_m2s),
        .m_o      (cpu_s2m),
        .dmem_o   (dmem_m2s),
        .imem_o   (imem_m2s),
        .gpio_o   (gpio_m2s),
        .dmem_i   (dmem_s2m),
        .imem_i   (imem_s2m),
        .gpio_i   (gpio_s2m)
    );

    // ==============================
    // Slaves
    // ==============================

    wb_ram #(.DEPTH(`SOC_DMEM_DEPTH)) u_dmem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (dmem_m2s),
        .wb_o     (dmem_s2m)
    );

    wb_ram #(.DEPTH(`SOC_IMEM_DEPTH)) u_imem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (imem_m2s),
        .wb_o     (imem_s2m)
    );

    gpio_wb u_gpio (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .wb_i      (gpio_m2s),
        .wb_o      (gpio_s2m),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

endmodule : soc_top

//--- hw/wb_intercon.sv
`timescale 1ns/1ns
`include "soc_cfg.svh"

module wb_intercon
    import soc_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,
    input  wb_m2s_t m_i,
    output wb_s2m_t m_o,
    output wb_m2s_t dmem_o,
    output wb_m2s_t imem_o,
    output wb_m2s_t gpio_o,
    input  wb_s2m_t dmem_i,
    input  wb_s2m_t imem_i,
    input  wb_s2m_t gpio_i
);

    region_e region;
    logic    err_q;

    // Region from the top address nibble
    always_comb
    begin
        case (m_i.adr[31:28])
            `SOC_DMEM_BASE: region = reg_dmem;
            `SOC_IMEM_BASE: region = reg_imem;
            `SOC_GPIO_BASE: region = reg_gpio;
            default:        region = reg_none;
        endcase
    end

    // Only the selected slave sees cyc and stb
    always_comb
    begin
        dmem_o     = m_i;
        imem_o     = m_i;
        gpio_o     = m_i;
        dmem_o.cyc = m_i.cyc && (region == reg_dmem);
        dmem_o.stb = m_i.stb && (region == reg_dmem);
        imem_o.cyc = m_i.cyc && (region == reg_imem);
        imem_o.stb = m_i.stb && (region == reg_imem);
        gpio_o.cyc = m_i.cyc && (region == reg_gpio);
        gpio_o.stb = m_i.stb && (region == reg_gpio);
    end

    // Error responder for unmapped space pulses once per access
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            err_q <= 1'b0;
        else
            err_q <= m_i.cyc && m_i.stb && (region == reg_none) && !err_q;
    end

    always_comb
    begin
        case (region)
            reg_dmem: m_o = dmem_i;
            reg_imem: m_o = imem_i;
            reg_gpio: m_o = gpio_i;
            default:  m_o = '{dat: 32'h0, ack: 1'b0, err: err_q};
        endcase
    end

endmodule : wb_intercon

//--- hw/wb_master_bridge.sv
`timescale 1ns/1ns

module wb_master_bridge
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  mem_req_t    req_i,
    output logic [31:0] rdata_o,
    output logic        stall_o,
    output logic        err_o,
    output wb_m2s_t     wb_o,
    input  wb_s2m_t     wb_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_done
    } state_e;

    state_e      state;
    logic [1:0]  lane;
    logic [31:0] rd_shift;
    logic [31:0] rd_ext;
    logic        bus_end;

    assign lane    = req_i.addr[1:0];
    assign bus_end = (state == st_bus) && (wb_i.ack || wb_i.err);

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state <= st_idle;
            err_o <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle: if (req_i.read || req_i.write) state <= st_bus;
                st_bus:
                begin
                    if (bus_end)
                    begin
                        state <= st_done;
                        err_o <= wb_i.err;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Processor is held from the request cycle until done
    assign stall_o = (state == st_bus) ||
                     ((state == st_idle) && (req_i.read || req_i.write));

    // Request is held by the processor, so the bus fields follow it directly
    always_comb
    begin
        wb_o.adr = {req_i.addr[31:2], 2'b00};
        wb_o.dat = req_i.wdata << {lane, 3'b000};
        wb_o.we  = req_i.write;
        wb_o.cyc = (state == st_bus);
        wb_o.stb = (state == st_bus);
        case (req_i.op)
            op_byte, op_byte_u: wb_o.sel = 4'b0001 << lane;
            op_half, op_half_u: wb_o.sel = 4'b0011 << lane;
            default:            wb_o.sel = 4'b1111;
        endcase
    end

    // Load lane back to bit 0, then extend
    assign rd_shift = wb_i.dat >> {lane, 3'b000};

    always_comb
    begin
        case (req_i.op)
            op_byte:   rd_ext = {{24{rd_shift[7]}}, rd_shift[7:0]};
            op_half:   rd_ext = {{16{rd_shift[15]}}, rd_shift[15:0]};
            op_byte_u: rd_ext = {24'h0, rd_shift[7:0]};
            op_half_u: rd_ext = {16'h0, rd_shift[15:0]};
            default:   rd_ext = rd_shift;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (bus_end) rdata_o <= wb_i.err ? 32'h0 : rd_ext;
    end

endmodule : wb_master_bridge

//--- hw/wb_ram.sv
`timescale 1ns/1ns

module wb_ram
    import soc_pkg::*;
#(
    parameter int DEPTH = 128
) (
    input  logic    clk,
    input  logic    arst_n_i,
    input  wb_m2s_t wb_i,
    output wb_s2m_t wb_o
);

    localparam int AW = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] word_idx;
    logic          access;
    logic          ack_q;
    logic [31:0]   dat_q;

    // Word index wraps at DEPTH
    assign word_idx = wb_i.adr[AW+1:2];
    assign access   = wb_i.cyc && wb_i.stb && !ack_q;

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            ack_q <= 1'b0;
        else
            ack_q <= access;
    end

    always_ff @(posedge clk)
    begin
        if (access)
        begin
            dat_q <= mem[word_idx];
            if (wb_i.we)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (wb_i.sel[i]) mem[word_idx][8*i +: 8] <= wb_i.dat[8*i +: 8];
                end
            end
        end
    end

    assign wb_o = '{dat: dat_q, ack: ack_q, err: 1'b0};

endmodule : wb_ram

//--- soc.f
+incdir+hw
hw/soc_pkg.sv
hw/wb_master_bridge.sv
hw/wb_intercon.sv
hw/wb_ram.sv
hw/gpio_wb.sv
hw/soc_top.sv
testbench/tb_soc.sv

//--- testbench/soc_stimulus.txt
# op size(funct3) addr wdata gpio_in exp_rdata exp_err, all values hex
# exp_rdata is compared on reads only
write 2 00000010 deadbeef 00000000 00000000 0
read  2 00000010 00000000 00000000 deadbeef 0
write 2 10000020 cafef00d 00000000 00000000 0
read  2 10000020 00000000 00000000 cafef00d 0
write 1 10000022 ffff1234 00000000 00000000 0
read  2 10000020 00000000 00000000 1234f00d 0
write 2 00000040 11223344 00000000 00000000 0
write 0 00000041 ffffffa5 00000000 00000000 0
write 0 00000043 1234567e 00000000 00000000 0
read  2 00000040 00000000 00000000 7e22a544 0
write 1 00000040 ffff8001 00000000 00000000 0
read  2 00000040 00000000 00000000 7e228001 0
write 0 00000042 00000099 00000000 00000000 0
read  2 00000040 00000000 00000000 7e998001 0
read  0 00000040 00000000 00000000 00000001 0
read  0 00000041 00000000 00000000 ffffff80 0
read  4 00000041 00000000 00000000 00000080 0
read  0 00000042 00000000 00000000 ffffff99 0
read  4 00000043 00000000 00000000 0000007e 0
read  1 00000040 00000000 00000000 ffff8001 0
read  5 00000040 00000000 00000000 00008001 0
read  1 00000042 00000000 00000000 00007e99 0
write 2 20000000 a5a50f0f 00000000 00000000 0
write 2 20000004 0000ffff 00000000 00000000 0
write 0 20000006 0000003c 00000000 00000000 0
read  2 20000000 00000000 00000000 a5a50f0f 0
read  2 20000004 00000000 00000000 003cffff 0
read  5 20000002 00000000 00000000 0000a5a5 0
write 2 20000008 ffffffff 12345678 00000000 0
read  2 20000008 00000000 12345678 12345678 0
read  2 2000000c 00000000 12345678 00000000 0
write 2 30000010 12345678 12345678 00000000 1
read  2 30000010 00000000 12345678 00000000 1
read  0 f0000040 00000000 12345678 00000000 1
read  2 00000010 00000000 12345678 deadbeef 0
read  2 00000040 00000000 12345678 7e998001 0

//--- testbench/tb_soc.sv
`timescale 1ns/1ns
`include "soc_cfg.svh"

module tb_soc
    import soc_pkg::*;
();

    localparam int MAX_WAIT = 20;

    logic        clk = 1'b0;
    logic        arst_n_i;
    mem_req_t    req_i;
    logic [31:0] rdata_o;
    logic        stall_o;
    logic        err_o;
    logic [31:0] gpio_i;
    logic [31:0] gpio_o;
    logic [31:0] gpio_oe_o;

    // Expected contents of the GPIO output registers
    logic [31:0] gpio_out_exp;
    logic [31:0] gpio_oe_exp;

    int checks;
    int data_errs;
    int err_errs;
    int gpio_errs;
    int other_errs;

    soc_top dut0 (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .req_i     (req_i),
        .rdata_o   (rdata_o),
        .stall_o   (stall_o),
        .err_o     (err_o),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

    always #10 clk = ~clk;

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            data_errs++;
            $display("error %s rdata: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            err_errs++;
            $display("error %s err: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_gpio(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            gpio_errs++;
            $display("error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    // Bytes of a store land at lane, lane+1, ... of the word
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] wdata,
                                                input mem_op_e op, input logic [1:0] lane);
        logic [31:0] res;
        int          nbytes;
        res = old;
        case (op)
            op_byte, op_byte_u: nbytes = 1;
            op_half, op_half_u: nbytes = 2;
            default:            nbytes = 4;
        endcase
        for (int i = 0; i < nbytes; i++)
            res[8*(int'(lane) + i) +: 8] = wdata[8*i +: 8];
        return res;
    endfunction

    // ==============================
    // One processor access
    // ==============================

    task automatic apply_access(input string name, input logic is_read, input logic [2:0] size,
                                input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [31:0] gpio_val, input logic [31:0] exp_rdata,
                                input logic exp_err);
        int          cycles;
        logic        done;
        logic [31:0] rdata;
        logic        err;
        cycles = 0;
        done   = 1'b0;
        gpio_i = gpio_val;
        req_i  = '{addr: addr, wdata: wdata, read: is_read, write: !is_read,
                   op: mem_op_e'(size)};
        // Stall drops in the done cycle
        while (!done && cycles < MAX_WAIT)
        begin
            @(negedge clk);
            cycles++;
            if (stall_o === 1'b0)
                done = 1'b1;
        end
        rdata = rdata_o;
        err   = err_o;
        if (!done)
        begin
            other_errs++;
            $display("%s: the access never completed within %0d cycles", name, MAX_WAIT);
        end
        else
        begin
            if (is_read)
                check_data(name, exp_rdata, rdata);
            check_err(name, exp_err, err);
            if (!is_read && !exp_err && addr[31:28] == `SOC_GPIO_BASE)
            begin
                if (addr[27:2] == 26'd0)
                    gpio_out_exp = merge_store(gpio_out_exp, wdata, mem_op_e'(size), addr[1:0]);
                if (addr[27:2] == 26'd1)
                    gpio_oe_exp = merge_store(gpio_oe_exp, wdata, mem_op_e'(size), addr[1:0]);
            end
            check_gpio({name, " gpio_o"}, gpio_out_exp, gpio_o);
            check_gpio({name, " gpio_oe_o"}, gpio_oe_exp, gpio_oe_o);
        end
        // Request dropped for one full cycle
        @(posedge clk);
        #2;
        req_i.read  = 1'b0;
        req_i.write = 1'b0;
        @(posedge clk);
        #2;
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial
    begin
        int          fd;
        int          rc;
        int          n;
        int          line_no;
        int          total;
        string       line;
        string       op_str;
        logic [2:0]  size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] gpio_val;
        logic [31:0] exp_rdata;
        logic        exp_err;

        checks       = 0;
        data_errs    = 0;
        err_errs     = 0;
        gpio_errs    = 0;
        other_errs   = 0;
        line_no      = 0;
        gpio_out_exp = 32'h0;
        gpio_oe_exp  = 32'h0;
        arst_n_i     = 1'b0;
        req_i        = '0;
        gpio_i       = 32'h0;

        repeat (8) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        @(posedge clk);
        #2;

        // Idle outputs straight after reset
        check_err("reset stall_o", 1'b0, stall_o);
        check_err("reset err_o", 1'b0, err_o);
        check_gpio("reset gpio_o", 32'h0, gpio_o);
        check_gpio("reset gpio_oe_o", 32'h0, gpio_oe_o);

        fd = $fopen("testbench/soc_stimulus.txt", "r");
        if (fd == 0)
        begin
            other_errs++;
            $display("could not open testbench/soc_stimulus.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                rc = $fgets(line, fd);
                line_no++;
                if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%s %h %h %h %h %h %h",
                            op_str, size, addr, wdata, gpio_val, exp_rdata, exp_err);
                if (n != 7 || (op_str != "read" && op_str != "write"))
                begin
                    other_errs++;
                    $display("stimulus line %0d could not be parsed", line_no);
                    continue;
                end
                apply_access($sformatf("line %0d %s %08h", line_no, op_str, addr),
                             op_str == "read", size, addr, wdata, gpio_val, exp_rdata, exp_err);
            end
            $fclose(fd);
        end

        total = data_errs + err_errs + gpio_errs + other_errs;
        $display("%0d checks, %0d errors (data %0d, err %0d, gpio %0d, other %0d)",
                 checks, total, data_errs, err_errs, gpio_errs, other_errs);
        if (total == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule : tb_soc
